//--- arbiter/outputArbiter.sv
`timescale 1ns/10ps

module outputArbiter (
  input logic clk,
  input logic rst,
  input portPkg::bufT bufs [portPkg::NumPorts],
  input logic [portPkg::NumPorts-1:0] headerLoad,
  input logic sent,
  output portPkg::grantT grant
);

  import flitPkg::*;
  import portPkg::*;

  logic [NumPorts-1:0] expired;
  grantT nextGrant;
  portIdxT owner;
  logic midPacket;
  logic hold;

  function automatic portIdxT ownerOf(grantT g);
    portIdxT idx;
    idx = PortL;
    for (int i = 0; i < NumPorts; i++)
    begin
      if (g[i+1])
        idx = portIdxT'(i);
    end
    return idx;
  endfunction

  function automatic portIdxT nextPort(portIdxT p);
    return (p == PortS) ? PortL : portIdxT'(p + 1'b1);
  endfunction

  function automatic grantT grantOf(portIdxT p);
    return grantT'(1) << (p + 1);
  endfunction

  for (genvar i = 0; i < NumPorts; i++)
  begin : timerGen
    packetTimer portTimer (
      .clk(clk),
      .rst(rst),
      .budget(bufs[i].budget),
      .load(headerLoad[i]),
      .run(grant[i+1]),
      .sent(sent),
      .expired(expired[i])
    );
  end

  assign owner = ownerOf(grant);

  // Owner also holds across the gap between two flits of one packet
  assign hold = bufs[owner].valid || midPacket;

  always_comb
  begin
    portIdxT cand;
    int tries;
    cand = (grant == GrantIdle) ? PortL : nextPort(owner);
    tries = (grant == GrantIdle) ? NumPorts : NumPorts - 1; // Owner is not searched again
    nextGrant = GrantIdle;
    if (grant != GrantIdle && hold && !expired[owner])
      nextGrant = grant;
    else
    begin
      for (int k = 0; k < NumPorts; k++)
      begin
        if (k < tries && nextGrant == GrantIdle && bufs[cand].valid)
          nextGrant = grantOf(cand);
        cand = nextPort(cand);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant <= GrantIdle;
      midPacket <= 1'b0;
    end
    else
    begin
      grant <= nextGrant;
      if (nextGrant != grant)
        midPacket <= 1'b0;
      else if (sent)
        midPacket <= (bufs[owner].flit.kind != KindTail); // Popped flit still held here
    end
  end

  grantOneHot: assert property (
    @(posedge clk) disable iff (rst)
    $onehot(grant)
  );

endmodule

//--- arbiter/packetTimer.sv
`timescale 1ns/10ps

module packetTimer (
  input logic clk,
  input logic rst,
  input flitPkg::lengthT budget,
  input logic load,
  input logic run,
  input logic sent,
  output logic expired
);

  import flitPkg::*;

  lengthT limit;
  lengthT count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (load)
        limit <= budget;
      if (load || !run)
        count <= '0; // New packet or grant lost
      else if (sent)
        count <= count + 1'b1; // Counts transfers, not cycles
    end
  end

  assign expired = (count == limit);

endmodule

//--- common/flitPkg.sv
package flitPkg;

  localparam int KindW = 3;
  localparam int DestW = 4;
  localparam int LengthW = 12;
  localparam int DataW = DestW + LengthW;

  typedef logic [KindW-1:0] flitKindT;

  localparam flitKindT KindIdle = 3'd0;
  localparam flitKindT KindHeader = 3'd1;
  localparam flitKindT KindBody = 3'd2;
  localparam flitKindT KindTail = 3'd3;

  typedef logic [LengthW-1:0] lengthT; // Packet budget in flits

  typedef struct packed {
    logic [DestW-1:0] dest;
    lengthT length;
  } headerT;

  // Header flits carry dest and length, the others carry raw payload
  typedef union packed {
    headerT header;
    logic [DataW-1:0] payload;
  } flitDataU;

  typedef struct packed {
    flitKindT kind;
    flitDataU data;
  } flitT;

endpackage

//--- common/portPkg.sv
package portPkg;

  localparam int NumPorts = 5;

  // Port order L, N, E, W, S
  typedef logic [2:0] portIdxT;

  localparam portIdxT PortL = 3'd0;
  localparam portIdxT PortS = 3'd4;

  // Bit 0 idle, bits 1 to 5 for L through S
  typedef logic [NumPorts:0] grantT;

  localparam grantT GrantIdle = 6'b000001;

  typedef struct packed {
    logic req;
    flitPkg::flitT flit;
  } inChanT;

  typedef struct packed {
    logic valid;
    flitPkg::flitT flit;
    flitPkg::lengthT budget; // Length of the last header seen
  } bufT;

endpackage

//--- hdl/flitReceiver.sv
`timescale 1ns/10ps

module flitReceiver (
  input logic clk,
  input logic rst,
  input portPkg::inChanT inChan,
  output logic inAck,
  input logic pop,
  output portPkg::bufT rxBuf,
  output logic headerLoad
);

  import flitPkg::*;

  logic capture;
  logic heldValid;
  flitT heldFlit;
  lengthT heldBudget;

  assign capture = inChan.req && !inAck && !heldValid; // Empty slot and fresh request

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      inAck <= 1'b0;
      heldValid <= 1'b0;
      headerLoad <= 1'b0;
    end
    else
    begin
      headerLoad <= capture && (inChan.flit.kind == KindHeader); // Budget ready next cycle
      if (capture)
      begin
        inAck <= 1'b1;
        heldValid <= 1'b1;
      end
      else
      begin
        if (!inChan.req)
          inAck <= 1'b0;
        if (pop)
          heldValid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (capture)
    begin
      heldFlit <= inChan.flit;
      if (inChan.flit.kind == KindHeader)
        heldBudget <= inChan.flit.data.header.length;
    end
  end

  assign rxBuf = '{valid: heldValid, flit: heldFlit, budget: heldBudget};

  // Sender must hold the flit until it sees ack
  flitHeldDuringAck: assert property (
    @(posedge clk) disable iff (rst)
    inChan.req && inAck |-> inChan.flit == heldFlit
  );

endmodule

//--- hdl/outputSwitch.sv
`timescale 1ns/10ps

module outputSwitch (
  input logic clk,
  input logic rst,
  input portPkg::grantT grant,
  input portPkg::bufT bufs [portPkg::NumPorts],
  output logic outReq,
  output flitPkg::flitT outFlit,
  input logic outAck,
  output logic [portPkg::NumPorts-1:0] pop,
  output logic sent
);

  import portPkg::*;

  bufT selBuf;
  logic [NumPorts-1:0] srcMask; // Port granted at transfer start
  logic drain;
  logic start;

  always_comb
  begin
    selBuf = '0;
    for (int i = 0; i < NumPorts; i++)
    begin
      if (grant[i+1])
        selBuf = bufs[i];
    end
  end

  assign start = !outReq && !drain && selBuf.valid;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outReq <= 1'b0;
      drain <= 1'b0;
      srcMask <= '0;
      pop <= '0;
      sent <= 1'b0;
    end
    else
    begin
      pop <= '0;
      sent <= 1'b0;
      if (start)
      begin
        outReq <= 1'b1;
        srcMask <= grant[NumPorts:1];
      end
      else if (outReq && outAck)
      begin
        outReq <= 1'b0;
        drain <= 1'b1; // Wait for ack to drop
        pop <= srcMask;
        sent <= 1'b1;
      end
      else if (drain && !outAck)
        drain <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (start)
      outFlit <= selBuf.flit;
  end

  // Request and flit stay put until the receiver acks
  outFlitHeld: assert property (
    @(posedge clk) disable iff (rst)
    outReq && !outAck |=> outReq && $stable(outFlit)
  );

endmodule

//--- hdl/routerOutputPort.sv
`timescale 1ns/10ps

module routerOutputPort (
  input logic clk,
  input logic rst,
  input portPkg::inChanT inChan [portPkg::NumPorts],
  output logic [portPkg::NumPorts-1:0] inAck,
  output logic outReq,
  output flitPkg::flitT outFlit,
  input logic outAck
);

  import portPkg::*;

  bufT bufs [NumPorts];
  logic [NumPorts-1:0] pop;
  logic [NumPorts-1:0] headerLoad;
  grantT grant;
  logic sent;

  for (genvar i = 0; i < NumPorts; i++)
  begin : rxGen
    flitReceiver rxPort (
      .clk(clk),
      .rst(rst),
      .inChan(inChan[i]),
      .inAck(inAck[i]),
      .pop(pop[i]),
      .rxBuf(bufs[i]),
      .headerLoad(headerLoad[i]) // Loads this port's timer
    );
  end

  outputArbiter arbiter (
    .clk(clk),
    .rst(rst),
    .bufs(bufs),
    .headerLoad(headerLoad),
    .sent(sent),
    .grant(grant)
  );

  outputSwitch switch (
    .clk(clk),
    .rst(rst),
    .grant(grant),
    .bufs(bufs),
    .outReq(outReq),
    .outFlit(outFlit),
    .outAck(outAck),
    .pop(pop),
    .sent(sent)
  );

endmodule

//--- routerOutputPort.f
common/flitPkg.sv
common/portPkg.sv
hdl/flitReceiver.sv
arbiter/packetTimer.sv
arbiter/outputArbiter.sv
hdl/outputSwitch.sv
hdl/routerOutputPort.sv
testbench/routerOutputPortTb.sv

//--- testbench/portStimulus.txt
# phase port kind data: phase 0 runs alone, phase 1 starts once it has drained
# port 0..4 is L N E W S, kind 1 header 2 body 3 tail, data 16-bit hex
0 0 1 1003
0 0 2 A001
0 0 3 A002
1 0 1 2001
1 0 2 A011
1 0 3 A012
1 1 1 3002
1 1 2 B001
1 1 2 B002
1 1 3 B003
1 2 1 4004
1 2 2 C001
1 2 3 C002
1 3 1 5003
1 3 2 D001
1 3 3 D002
1 3 1 6002
1 3 3 D011
1 4 1 7005
1 4 2 E001
1 4 2 E002
1 4 2 E003
1 4 3 E004

//--- testbench/routerOutputPortTb.sv
`timescale 1ns/10ps

module routerOutputPortTb;

  import flitPkg::*;
  import portPkg::*;

  localparam int MaxFlits = 64;
  localparam int HandshakeLimit = 1000; // Cycles per handshake wait
  localparam int RunLimit = 5000;
  localparam string StimFile = "testbench/portStimulus.txt";

  logic clk;
  logic rst;
  inChanT inChan [NumPorts];
  logic [NumPorts-1:0] inAck;
  logic outReq;
  flitT outFlit;
  logic outAck;

  flitT stimFlit [MaxFlits];
  int stimPort [MaxFlits];
  int stimPhase [MaxFlits];
  int numFlits = 0;
  int phaseZeroLeft = 0;
  int phaseZeroPort = 0;

  int nextExp [NumPorts];
  int accepted [NumPorts];
  int consumed [NumPorts];
  int curLen [NumPorts];
  flitKindT lastKind [NumPorts];
  int owner = -1; // Port of the last output flit
  int windowCount = 0;
  bit forceSwitch = 0;
  int outCount = 0;

  int valueErrors = 0;
  int orderErrors = 0;
  int timeouts = 0;
  bit timedOut = 0;
  bit started = 0;
  bit responderDone = 0;
  logic [31:0] lfsrState = 32'h7766;

  routerOutputPort i_routerOutputPort (
    .clk(clk),
    .rst(rst),
    .inChan(inChan),
    .inAck(inAck),
    .outReq(outReq),
    .outFlit(outFlit),
    .outAck(outAck)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h80200003;
    return s >> 1;
  endfunction

  function automatic int takeBits(input int n);
    int value;
    value = 0;
    for (int b = 0; b < n; b++)
    begin
      value = (value << 1) | lfsrState[0];
      lfsrState = lfsrNext(lfsrState);
    end
    return value;
  endfunction

  function automatic int nextIndexOf(input int p, input int from);
    for (int i = from; i < numFlits; i++)
    begin
      if (stimPort[i] == p)
        return i;
    end
    return numFlits;
  endfunction

  function automatic int matchHead(input flitT got);
    int src;
    src = -1;
    for (int p = 0; p < NumPorts; p++)
    begin
      if (src < 0 && nextExp[p] < numFlits && stimFlit[nextExp[p]] === got)
        src = p;
    end
    return src;
  endfunction

  // A port with an acked flit not yet seen at the output holds a valid buffer
  function automatic bit othersHeld(input int src);
    bit held;
    held = 0;
    for (int p = 0; p < NumPorts; p++)
    begin
      if (p != src && accepted[p] > consumed[p])
        held = 1;
    end
    return held;
  endfunction

  task automatic reportTimeout(input string what);
    timeouts++;
    timedOut = 1'b1;
    $display("Timeout at %0t: %s", $time, what);
  endtask

  task automatic compareFlit(input string name, input flitT got, input flitT exp);
    if (got !== exp)
    begin
      valueErrors++;
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compareKind(input string name, input flitKindT got, input flitKindT exp);
    if (got !== exp)
    begin
      valueErrors++;
      $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic compareCount(input string name, input int got, input int exp);
    if (got != exp)
    begin
      valueErrors++;
      $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic loadStimulus();
    int fd;
    int n;
    int phase;
    int port;
    int kind;
    logic [15:0] data;
    string line;
    flitT f;
    fd = $fopen(StimFile, "r");
    if (fd == 0)
    begin
      orderErrors++;
      $display("Cannot open stimulus file %s", StimFile);
      return;
    end
    while (!$feof(fd))
    begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.getc(0) != "#")
      begin
        n = $sscanf(line, "%d %d %d %h", phase, port, kind, data);
        if (n == 4 && numFlits < MaxFlits)
        begin
          f.kind = flitKindT'(kind);
          f.data.payload = data;
          stimFlit[numFlits] = f;
          stimPort[numFlits] = port;
          stimPhase[numFlits] = phase;
          if (phase == 0)
          begin
            phaseZeroLeft++;
            phaseZeroPort = port; // Phase 0 uses a single input
          end
          numFlits++;
        end
      end
    end
    $fclose(fd);
    if (numFlits == 0)
    begin
      orderErrors++;
      $display("Stimulus file %s holds no flits", StimFile);
    end
    for (int p = 0; p < NumPorts; p++)
    begin
      nextExp[p] = nextIndexOf(p, 0);
      accepted[p] = 0;
      consumed[p] = 0;
      curLen[p] = 0;
      lastKind[p] = KindIdle;
    end
  endtask

  task automatic waitStart();
    int cycles;
    cycles = 0;
    while (!started && !timedOut)
    begin
      @(negedge clk);
      cycles = cycles + 1;
      if (!started && cycles > HandshakeLimit)
        reportTimeout("reset was never released");
    end
  endtask

  task automatic waitPhaseZero();
    int cycles;
    cycles = 0;
    while (phaseZeroLeft > 0 && !timedOut)
    begin
      @(negedge clk);
      cycles = cycles + 1;
      if (phaseZeroLeft > 0 && cycles > HandshakeLimit)
        reportTimeout("the single-packet phase did not drain");
    end
  endtask

  task automatic waitInAck(input int p, input logic level);
    int cycles;
    bit seen;
    cycles = 0;
    seen = 0;
    while (!seen && !timedOut)
    begin
      @(negedge clk);
      cycles = cycles + 1;
      if (inAck[p] === level)
        seen = 1;
      else if (cycles > HandshakeLimit)
        reportTimeout($sformatf("inAck[%0d] did not go to %0b", p, level));
    end
  endtask

  task automatic waitOutReq(input logic level);
    int cycles;
    bit seen;
    cycles = 0;
    seen = 0;
    while (!seen && !timedOut)
    begin
      @(negedge clk);
      cycles = cycles + 1;
      if (outReq === level)
        seen = 1;
      else if (cycles > HandshakeLimit)
        reportTimeout($sformatf("outReq did not go to %0b", level));
    end
  endtask

  task automatic drivePort(input int p);
    inChanT chan;
    waitStart();
    for (int i = 0; i < numFlits; i++)
    begin
      if (stimPort[i] == p && !timedOut)
      begin
        if (stimPhase[i] > 0)
          waitPhaseZero();
        chan.req = 1'b1;
        chan.flit = stimFlit[i];
        @(posedge clk);
        inChan[p] <= chan;
        waitInAck(p, 1'b1);
        accepted[p]++;
        chan.req = 1'b0;
        @(posedge clk);
        inChan[p] <= chan; // Flit held, only req drops
        waitInAck(p, 1'b0);
      end
    end
  endtask

  task automatic checkOutput(input flitT got);
    int src;
    int idx;
    bit ownerMid;
    string name;
    outCount++;
    if (phaseZeroLeft > 0)
    begin
      src = phaseZeroPort;
      compareFlit("outFlit", got, stimFlit[nextExp[src]]);
    end
    else
      src = matchHead(got);
    if (src < 0)
    begin
      orderErrors++;
      $display("Output flit %h at %0t is not the next flit of any input", got, $time);
      return;
    end
    idx = nextExp[src];
    if (stimPhase[idx] == 0)
      phaseZeroLeft--;
    nextExp[src] = nextIndexOf(src, idx + 1);
    consumed[src]++;
    name = $sformatf("outFlit.kind from port %0d", src);
    if (lastKind[src] == KindIdle || lastKind[src] == KindTail)
      compareKind(name, got.kind, KindHeader);
    else if (got.kind != KindTail)
      compareKind(name, got.kind, KindBody);
    ownerMid = owner >= 0 && (lastKind[owner] == KindHeader || lastKind[owner] == KindBody);
    if (src != owner && ownerMid && windowCount != curLen[owner])
    begin
      orderErrors++;
      $display("Port %0d lost the output after %0d of %0d flits inside a packet at %0t",
               owner, windowCount, curLen[owner], $time);
    end
    if (src == owner && forceSwitch)
    begin
      orderErrors++;
      $display("Port %0d kept the output past its header length while another port waited",
               src);
    end
    if (src != owner || got.kind == KindHeader || windowCount == curLen[src])
      windowCount = 0; // New grant window
    if (got.kind == KindHeader)
      curLen[src] = got.data.header.length;
    windowCount++;
    owner = src;
    lastKind[src] = got.kind;
    forceSwitch = got.kind != KindTail && windowCount == curLen[src] && othersHeld(src);
  endtask

  task automatic respondOutput();
    int delay;
    waitStart();
    while (outCount < numFlits && !timedOut)
    begin
      waitOutReq(1'b1);
      if (!timedOut)
      begin
        checkOutput(outFlit);
        delay = takeBits(2); // 0 to 3 cycles
        repeat (delay) @(posedge clk);
        @(posedge clk);
        outAck <= 1'b1;
        waitOutReq(1'b0);
        @(posedge clk);
        outAck <= 1'b0;
      end
    end
    responderDone = 1'b1;
  endtask

  for (genvar g = 0; g < NumPorts; g++)
  begin : driverGen
    initial
    begin
      drivePort(g);
    end
  end

  initial
  begin
    respondOutput();
  end

  initial
  begin : mainSeq
    int cycles;
    int total;
    bit extraSeen;
    rst = 1'b1;
    outAck = 1'b0;
    for (int p = 0; p < NumPorts; p++)
      inChan[p] = '0;
    loadStimulus();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    started = 1'b1;
    cycles = 0;
    while (!responderDone && !timedOut)
    begin
      @(negedge clk);
      cycles = cycles + 1;
      if (!responderDone && cycles > RunLimit)
        reportTimeout("the output did not deliver every flit in time");
    end
    if (!timedOut)
    begin
      extraSeen = 0;
      repeat (20)
      begin
        @(negedge clk);
        if (outReq === 1'b1)
          extraSeen = 1;
      end
      if (extraSeen)
      begin
        orderErrors++;
        $display("Output raised a request after every expected flit was delivered");
      end
      total = 0;
      for (int p = 0; p < NumPorts; p++)
      begin
        total += consumed[p];
        if (nextIndexOf(p, 0) < numFlits)
          compareKind($sformatf("last kind from port %0d", p), lastKind[p], KindTail);
      end
      compareCount("flits matched", total, numFlits);
    end
    $display("Summary: %0d value errors, %0d order errors, %0d timeouts",
             valueErrors, orderErrors, timeouts);
    if (valueErrors + orderErrors + timeouts == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule
